/* design/dcache_consts.svh */
/*
  Size constants for the two-way data cache.
  The tag, offset and index widths must stay consistent with a 32-bit address.
  The round-robin replacement assumes a power-of-two way count.
*/
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// associativity
`define DC_WAY_CNT 2

// 64 sets
`define DC_SET_BITS 6

// words per line and byte offset inside a line
`define DC_LINE_WORDS 4
`define DC_OFF_BITS 4

// 32 - set bits - offset bits
`define DC_TAG_BITS 22

// data RAM word index, set plus word-in-line
`define DC_WIDX_BITS 8

`endif

/* design/dcache_pkg.sv */
/*
  Shared types of the data cache and its testbench.
  Addresses are physical; there is no translation.
*/
`include "dcache_consts.svh"

package dcache_pkg;

  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_INV
  } dc_op_e;

  typedef enum logic [1:0] {
    SZ_B,
    SZ_H,
    SZ_W
  } dc_size_e;

  typedef struct packed {
    logic [31:0] vaddr;
    dc_op_e      op;
    dc_size_e    size;
    logic        sign_ext;
    logic        uncached;
    logic [31:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic                    valid;
    logic [`DC_TAG_BITS-1:0] tag;
  } dcache_tag_t;

  // job flags are one-hot, hit_write lasts a single cycle
  typedef struct packed {
    logic                   refill_req;
    logic                   uncached_read;
    logic                   hit_write;
    logic                   mem_write;
    logic                   inv;
    logic [31:0]            addr;
    dc_size_e               size;
    logic [`DC_WAY_CNT-1:0] wsel;
    logic [3:0]             wstrobe;
    logic [31:0]            wdata;
  } rport_state_t;

  typedef struct packed {
    logic        done;
    logic [31:0] rdata;
  } wport_state_t;

  typedef struct packed {
    logic [`DC_WAY_CNT-1:0][3:0]  data_we;
    logic [`DC_WIDX_BITS-1:0]     data_waddr;
    logic [31:0]                  data_wdata;
    logic [`DC_WAY_CNT-1:0]       tag_we;
    logic [`DC_SET_BITS-1:0]      tag_waddr;
    dcache_tag_t                  tag_wdata;
  } wport_wreq_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic [3:0]  wstrobe;
    logic [31:0] wdata;
  } mem_req_t;

  typedef enum logic [2:0] {
    S_NORMAL,
    S_REFILL,
    S_UNCACHED_READ,
    S_MEM_WRITE,
    S_INV,
    S_RESP
  } rport_fsm_e;

  typedef enum logic [1:0] {
    W_IDLE,
    W_MEM_REQ,
    W_MEM_WAIT,
    W_DONE
  } wport_fsm_e;

endpackage

/* design/dcache_sdp_ram.sv */
/*
  Simple dual-port RAM, one write port with lane enables and one read port.
  Read data is registered and is read-first against a write to the same word.
  Contents start at zero through the FPGA init value; reset only clears rdata_o.
*/
`timescale 1ns/1ps

module dcache_sdp_ram #(
  parameter int WIDTH = 32,
  parameter int LANES = 4,
  parameter int DEPTH = 256
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  logic [LANES-1:0]         we_i,
  input  logic [WIDTH-1:0]         wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic [WIDTH-1:0]         rdata_o
);

  localparam int LANE_W = WIDTH / LANES;

  logic [LANES-1:0][LANE_W-1:0] mem [DEPTH];

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < LANES; l++) begin
      if (we_i[l]) begin
        mem[waddr_i][l] <= wdata_i[l*LANE_W +: LANE_W];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata_o <= '0;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

/* design/dcache_rport.sv */
/*
  Load/store pipeline EX -> M1 -> M2 of the data cache.
  Owns only the RAM read side; every RAM write comes from dcache_wport and is snooped.
  M2 stalls the whole pipeline for any job that needs dcache_wport.
*/
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_rport
  import dcache_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  lsu_req_t                     req_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  output logic [31:0]                  resp_o,
  output logic                         resp_valid_o,
  input  logic [`DC_WAY_CNT-1:0][31:0] data_rdata_i,
  input  dcache_tag_t [`DC_WAY_CNT-1:0] tag_rdata_i,
  output logic [`DC_WIDX_BITS-1:0]     raddr_o,
  output rport_state_t                 rstate_o,
  input  wport_state_t                 wstate_i,
  input  wport_wreq_t                  wreq_i
);

  lsu_req_t ex_q, m1_q, m2_q;
  logic ex_v_q, m1_v_q, m2_v_q;
  logic stall, stall_q;
  rport_fsm_e fsm_q, fsm_d;
  wport_wreq_t wb_q;
  logic [`DC_WAY_CNT-1:0][31:0] m1_data, m1_data_hold_q;
  dcache_tag_t [`DC_WAY_CNT-1:0] m1_tag, m1_tag_hold_q;
  logic [`DC_WAY_CNT-1:0] m1_hit, hit_q;
  logic [31:0] m1_word, m2_word_q, m2_word_snp, ld_q, ld_word, ld_shift;
  logic [3:0] strobe;
  logic [31:0] wlane;

  function automatic logic [`DC_WIDX_BITS-1:0] widx(input logic [31:0] a);
    return a[`DC_OFF_BITS+`DC_SET_BITS-1:2];
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [3:0] we,
                                        input logic [31:0] nw);
    logic [31:0] r;
    r = old;
    for (int i = 0; i < 4; i++) begin
      if (we[i]) begin
        r[8*i +: 8] = nw[8*i +: 8];
      end
    end
    return r;
  endfunction

  // all three stages advance together
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_v_q <= 1'b0;
      m1_v_q <= 1'b0;
      m2_v_q <= 1'b0;
    end else if (!stall) begin
      ex_v_q <= req_valid_i;
      m1_v_q <= ex_v_q;
      m2_v_q <= m1_v_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ex_q <= req_i;
      m1_q <= ex_q;
      m2_q <= m1_q;
    end
  end

  assign req_ready_o = !stall;
  assign raddr_o = widx(ex_q.vaddr);

  // last cycle's write, the RAM read missed it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_q    <= '0;
      stall_q <= 1'b0;
    end else begin
      wb_q    <= wreq_i;
      stall_q <= stall;
    end
  end

  always_ff @(posedge clk) begin
    m1_data_hold_q <= m1_data;
    m1_tag_hold_q  <= m1_tag;
  end

  // M1 snoop and tag compare
  always_comb begin
    m1_word = '0;
    for (int w = 0; w < `DC_WAY_CNT; w++) begin
      m1_data[w] = stall_q ? m1_data_hold_q[w] : data_rdata_i[w];
      m1_tag[w]  = stall_q ? m1_tag_hold_q[w] : tag_rdata_i[w];
      if (wb_q.data_waddr == widx(m1_q.vaddr)) begin
        m1_data[w] = merge(m1_data[w], wb_q.data_we[w], wb_q.data_wdata);
      end
      if (wreq_i.data_waddr == widx(m1_q.vaddr)) begin
        m1_data[w] = merge(m1_data[w], wreq_i.data_we[w], wreq_i.data_wdata);
      end
      if (wb_q.tag_we[w] && wb_q.tag_waddr == m1_q.vaddr[`DC_OFF_BITS +: `DC_SET_BITS]) begin
        m1_tag[w] = wb_q.tag_wdata;
      end
      if (wreq_i.tag_we[w] && wreq_i.tag_waddr == m1_q.vaddr[`DC_OFF_BITS +: `DC_SET_BITS]) begin
        m1_tag[w] = wreq_i.tag_wdata;
      end
      m1_hit[w] = m1_tag[w].valid && !m1_q.uncached &&
                  m1_tag[w].tag == m1_q.vaddr[31 -: `DC_TAG_BITS];
      m1_word = m1_word | (m1_hit[w] ? m1_data[w] : 32'h0);
    end
  end

  // M2 keeps its hit word current while held
  always_comb begin
    m2_word_snp = m2_word_q;
    for (int w = 0; w < `DC_WAY_CNT; w++) begin
      if (hit_q[w] && wreq_i.data_waddr == widx(m2_q.vaddr)) begin
        m2_word_snp = merge(m2_word_snp, wreq_i.data_we[w], wreq_i.data_wdata);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      hit_q     <= m1_hit;
      m2_word_q <= m1_word;
    end else begin
      m2_word_q <= m2_word_snp;
    end
    if (wstate_i.done) begin
      ld_q <= wstate_i.rdata;
    end
  end

  // miss FSM
  always_comb begin
    fsm_d = fsm_q;
    case (fsm_q)
      S_NORMAL: begin
        if (m2_v_q) begin
          if (m2_q.op == OP_INV) begin
            fsm_d = S_INV;
          end else if (m2_q.op == OP_WRITE) begin
            fsm_d = S_MEM_WRITE;
          end else if (m2_q.uncached) begin
            fsm_d = S_UNCACHED_READ;
          end else if (!(|hit_q)) begin
            fsm_d = S_REFILL;
          end
        end
      end
      S_RESP: fsm_d = S_NORMAL;
      default: begin
        if (wstate_i.done) begin
          fsm_d = S_RESP;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fsm_q <= S_NORMAL;
    end else begin
      fsm_q <= fsm_d;
    end
  end

  assign stall = (fsm_q == S_NORMAL) ? (fsm_d != S_NORMAL) : (fsm_q != S_RESP);

  // store lanes, replicated data lands in every lane
  always_comb begin
    case (m2_q.size)
      SZ_B: begin
        strobe = 4'b0001 << m2_q.vaddr[1:0];
        wlane  = {4{m2_q.wdata[7:0]}};
      end
      SZ_H: begin
        strobe = 4'b0011 << {m2_q.vaddr[1], 1'b0};
        wlane  = {2{m2_q.wdata[15:0]}};
      end
      default: begin
        strobe = 4'b1111;
        wlane  = m2_q.wdata;
      end
    endcase
  end

  always_comb begin
    rstate_o               = '0;
    rstate_o.refill_req    = fsm_q == S_REFILL;
    rstate_o.uncached_read = fsm_q == S_UNCACHED_READ;
    rstate_o.hit_write     = fsm_q == S_NORMAL && m2_v_q && m2_q.op == OP_WRITE && (|hit_q);
    rstate_o.mem_write     = fsm_q == S_MEM_WRITE;
    rstate_o.inv           = fsm_q == S_INV;
    rstate_o.addr          = m2_q.vaddr;
    rstate_o.size          = m2_q.size;
    rstate_o.wsel          = hit_q;
    rstate_o.wstrobe       = strobe;
    rstate_o.wdata         = wlane;
  end

  // load formatting
  assign ld_word  = (fsm_q == S_RESP) ? ld_q : m2_word_q;
  assign ld_shift = ld_word >> {m2_q.vaddr[1:0], 3'b000};

  always_comb begin
    case (m2_q.size)
      SZ_B: resp_o = {{24{m2_q.sign_ext & ld_shift[7]}}, ld_shift[7:0]};
      SZ_H: resp_o = {{16{m2_q.sign_ext & ld_shift[15]}}, ld_shift[15:0]};
      default: resp_o = ld_word;
    endcase
  end

  assign resp_valid_o = m2_v_q && m2_q.op == OP_READ &&
                        ((fsm_q == S_NORMAL && !stall) || fsm_q == S_RESP);

endmodule

/* design/dcache_wport.sv */
/*
  Single write port of the data cache and master of the memory bus.
  One memory read outstanding at a time; a refill fetches words 0..3 in order.
  The victim comes from a per-set round-robin counter, invalid ways are not preferred.
*/
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_wport
  import dcache_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  rport_state_t rstate_i,
  output wport_state_t wstate_o,
  output wport_wreq_t  wreq_o,
  output mem_req_t     mem_req_o,
  output logic         mem_req_valid_o,
  input  logic         mem_req_ready_i,
  input  logic [31:0]  mem_rdata_i,
  input  logic         mem_rvalid_i
);

  localparam int VB = $clog2(`DC_WAY_CNT);
  localparam int BEAT_BITS = $clog2(`DC_LINE_WORDS);

  wport_fsm_e state_q, state_d;
  logic [BEAT_BITS-1:0] beat_q;
  logic [(1<<`DC_SET_BITS)-1:0][VB-1:0] rr_q;
  logic [31:0] rdata_q;
  logic [`DC_SET_BITS-1:0] set;
  logic last_beat, refill_beat;

  assign set = rstate_i.addr[`DC_OFF_BITS +: `DC_SET_BITS];
  assign last_beat = beat_q == BEAT_BITS'(`DC_LINE_WORDS - 1);
  assign refill_beat = state_q == W_MEM_WAIT && mem_rvalid_i && rstate_i.refill_req;

  always_comb begin
    state_d = state_q;
    case (state_q)
      W_IDLE: begin
        // hit_write needs only the RAM write below
        if (rstate_i.inv) begin
          state_d = W_DONE;
        end else if (rstate_i.refill_req || rstate_i.uncached_read || rstate_i.mem_write) begin
          state_d = W_MEM_REQ;
        end
      end
      W_MEM_REQ: begin
        if (mem_req_ready_i) begin
          state_d = rstate_i.mem_write ? W_DONE : W_MEM_WAIT;
        end
      end
      W_MEM_WAIT: begin
        if (mem_rvalid_i) begin
          state_d = (rstate_i.refill_req && !last_beat) ? W_MEM_REQ : W_DONE;
        end
      end
      default: state_d = W_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= W_IDLE;
      beat_q  <= '0;
      rr_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == W_IDLE) begin
        beat_q <= '0;
      end else if (refill_beat) begin
        beat_q <= beat_q + 1'b1;
      end
      if (refill_beat && last_beat) begin
        rr_q[set] <= rr_q[set] + 1'b1;
      end
    end
  end

  // keep the word the load asked for
  always_ff @(posedge clk) begin
    if (state_q == W_MEM_WAIT && mem_rvalid_i &&
        (rstate_i.uncached_read || beat_q == rstate_i.addr[BEAT_BITS+1:2])) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign wstate_o.done  = state_q == W_DONE;
  assign wstate_o.rdata = rdata_q;

  // RAM writes
  always_comb begin
    wreq_o = '0;
    wreq_o.data_waddr = {set, rstate_i.refill_req ? beat_q : rstate_i.addr[BEAT_BITS+1:2]};
    wreq_o.data_wdata = rstate_i.refill_req ? mem_rdata_i : rstate_i.wdata;
    wreq_o.tag_waddr  = set;
    wreq_o.tag_wdata.valid = !rstate_i.inv;
    wreq_o.tag_wdata.tag   = rstate_i.addr[31 -: `DC_TAG_BITS];
    for (int w = 0; w < `DC_WAY_CNT; w++) begin
      if (state_q == W_IDLE && rstate_i.hit_write && rstate_i.wsel[w]) begin
        wreq_o.data_we[w] = rstate_i.wstrobe;
      end
      if (refill_beat && rr_q[set] == VB'(w)) begin
        wreq_o.data_we[w] = 4'b1111;
        // tag goes in with the final word
        wreq_o.tag_we[w] = last_beat;
      end
      if (state_q == W_IDLE && rstate_i.inv) begin
        wreq_o.tag_we[w] = 1'b1;
      end
    end
  end

  // memory bus, request fields are stable while the job flag is held
  always_comb begin
    if (rstate_i.refill_req) begin
      mem_req_o.addr = {rstate_i.addr[31:`DC_OFF_BITS], beat_q, 2'b00};
    end else begin
      mem_req_o.addr = {rstate_i.addr[31:2], 2'b00};
    end
    mem_req_o.write   = rstate_i.mem_write;
    mem_req_o.wstrobe = rstate_i.wstrobe;
    mem_req_o.wdata   = rstate_i.wdata;
  end

  assign mem_req_valid_o = state_q == W_MEM_REQ;

endmodule

/* design/dcache_top.sv */
/*
  Data cache top: read port, write port and per-way data and tag RAMs.
  Write-through, no write-allocate; stores produce no response.
*/
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top
  import dcache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  lsu_req_t    req_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  output logic [31:0] resp_o,
  output logic        resp_valid_o,
  output mem_req_t    mem_req_o,
  output logic        mem_req_valid_o,
  input  logic        mem_req_ready_i,
  input  logic [31:0] mem_rdata_i,
  input  logic        mem_rvalid_i
);

  rport_state_t rstate;
  wport_state_t wstate;
  wport_wreq_t wreq;
  logic [`DC_WIDX_BITS-1:0] raddr;
  logic [`DC_WAY_CNT-1:0][31:0] data_rdata;
  dcache_tag_t [`DC_WAY_CNT-1:0] tag_rdata;

  dcache_rport rport_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o),
    .data_rdata_i (data_rdata),
    .tag_rdata_i  (tag_rdata),
    .raddr_o      (raddr),
    .rstate_o     (rstate),
    .wstate_i     (wstate),
    .wreq_i       (wreq)
  );

  dcache_wport wport_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .rstate_i        (rstate),
    .wstate_o        (wstate),
    .wreq_o          (wreq),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rdata_i     (mem_rdata_i),
    .mem_rvalid_i    (mem_rvalid_i)
  );

  for (genvar w = 0; w < `DC_WAY_CNT; w++) begin : g_way
    dcache_sdp_ram #(
      .WIDTH (32),
      .LANES (4),
      .DEPTH (1 << `DC_WIDX_BITS)
    ) data_ram_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .waddr_i (wreq.data_waddr),
      .we_i    (wreq.data_we[w]),
      .wdata_i (wreq.data_wdata),
      .raddr_i (raddr),
      .rdata_o (data_rdata[w])
    );

    // tag RAM is indexed by the set part of the word index
    dcache_sdp_ram #(
      .WIDTH ($bits(dcache_tag_t)),
      .LANES (1),
      .DEPTH (1 << `DC_SET_BITS)
    ) tag_ram_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .waddr_i (wreq.tag_waddr),
      .we_i    (wreq.tag_we[w]),
      .wdata_i (wreq.tag_wdata),
      .raddr_i (raddr[`DC_WIDX_BITS-1 -: `DC_SET_BITS]),
      .rdata_o (tag_rdata[w])
    );
  end

endmodule

/* tests/dcache_mem_model.sv */
/*
  Memory bus model of 1024 words, addresses wrap every 4 KB.
  One read outstanding, answered three cycles after it is accepted.
  Ready is low whenever stall_i is high or a read is pending.
*/
`timescale 1ns/1ps

module dcache_mem_model
  import dcache_pkg::*;
#(
  parameter int LATENCY = 3
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        stall_i,
  input  mem_req_t    req_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  output logic [31:0] rdata_o,
  output logic        rvalid_o
);

  logic [31:0] mem [1024];
  logic        busy_q;
  logic [1:0]  wait_q;
  logic [31:0] rd_q;
  logic [9:0]  idx;

  // preset word mixes every address bit
  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    end
  end

  assign idx = req_i.addr[11:2];
  assign req_ready_o = !stall_i && !busy_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q   <= 1'b0;
      wait_q   <= '0;
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= 1'b0;
      if (req_valid_i && req_ready_o) begin
        if (req_i.write) begin
          for (int l = 0; l < 4; l++) begin
            if (req_i.wstrobe[l]) begin
              mem[idx][8*l +: 8] <= req_i.wdata[8*l +: 8];
            end
          end
        end else begin
          busy_q <= 1'b1;
          wait_q <= 2'(LATENCY - 1);
          rd_q   <= mem[idx];
        end
      end else if (busy_q) begin
        // latency counted from the accepting edge
        if (wait_q == 0) begin
          busy_q   <= 1'b0;
          rvalid_o <= 1'b1;
          rdata_o  <= rd_q;
        end else begin
          wait_q <= wait_q - 1'b1;
        end
      end
    end
  end

endmodule

/* tests/dcache_tb.sv */
/*
  Directed testbench of the data cache against a 4 KB memory model.
  Test addresses stay below 4 KB so cache lines and model words match one to one.
*/
`timescale 1ns/1ps

module dcache_tb
  import dcache_pkg::*;
();

  localparam int TIMEOUT = 500;

  logic        clk;
  logic        rst_n;
  lsu_req_t    req;
  logic        req_valid;
  logic        req_ready;
  logic [31:0] resp;
  logic        resp_valid;
  mem_req_t    mem_req;
  logic        mem_req_valid;
  logic        mem_req_ready;
  logic [31:0] mem_rdata;
  logic        mem_rvalid;
  logic        mem_stall;
  logic [31:0] lfsr_q;

  int          check_errs;
  int          timeout_errs;
  int          rd_cnt;
  int          batch_cycles;
  mem_req_t    wr_log[$];
  lsu_req_t    batch_req[$];
  logic [31:0] batch_exp[$];

  dcache_top dcache_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .resp_o          (resp),
    .resp_valid_o    (resp_valid),
    .mem_req_o       (mem_req),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_rdata_i     (mem_rdata),
    .mem_rvalid_i    (mem_rvalid)
  );

  dcache_mem_model mem_model_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall_i     (mem_stall),
    .req_i       (mem_req),
    .req_valid_i (mem_req_valid),
    .req_ready_o (mem_req_ready),
    .rdata_o     (mem_rdata),
    .rvalid_o    (mem_rvalid)
  );

  always #10 clk = ~clk;

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic next_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  // roughly one stalled cycle in four
  always @(posedge clk) begin
    mem_stall <= next_bit() & next_bit();
  end

  // bus monitor, a transfer completes on the following edge
  always @(negedge clk) begin
    if (mem_req_valid && mem_req_ready) begin
      if (mem_req.write) begin
        wr_log.push_back(mem_req);
      end else begin
        rd_cnt++;
      end
    end
  end

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return mem_model_inst.mem[a[11:2]];
  endfunction

  function automatic logic [31:0] fmt_load(input logic [31:0] w, input logic [1:0] off,
                                           input dc_size_e sz, input logic sext);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[8*off +: 8];
    h = off[1] ? w[31:16] : w[15:0];
    case (sz)
      SZ_B: return sext ? {{24{b[7]}}, b} : {24'h0, b};
      SZ_H: return sext ? {{16{h[15]}}, h} : {16'h0, h};
      default: return w;
    endcase
  endfunction

  function automatic logic [31:0] store_merge(input logic [31:0] old, input logic [1:0] off,
                                              input dc_size_e sz, input logic [31:0] d);
    logic [31:0] r;
    r = old;
    case (sz)
      SZ_B: r[8*off +: 8] = d[7:0];
      SZ_H: r[16*off[1] +: 16] = d[15:0];
      default: r = d;
    endcase
    return r;
  endfunction

  // only the strobed lanes of wdata carry meaning
  function automatic mem_req_t store_req(input logic [31:0] a, input dc_size_e sz,
                                         input logic [31:0] d);
    mem_req_t m;
    m.addr  = {a[31:2], 2'b00};
    m.write = 1'b1;
    m.wdata = store_merge(32'h0, a[1:0], sz, d);
    case (sz)
      SZ_B: m.wstrobe = 4'b0001 << a[1:0];
      SZ_H: m.wstrobe = a[1] ? 4'b1100 : 4'b0011;
      default: m.wstrobe = 4'b1111;
    endcase
    return m;
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      check_errs++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("ERR %s: expected %0d, actual %0d", name, exp, act);
      check_errs++;
    end
  endtask

  task automatic check_mem_req(input string name, input mem_req_t exp, input mem_req_t act);
    logic [31:0] mask;
    mask = {{8{exp.wstrobe[3]}}, {8{exp.wstrobe[2]}}, {8{exp.wstrobe[1]}}, {8{exp.wstrobe[0]}}};
    if (act.addr !== exp.addr || act.write !== exp.write || act.wstrobe !== exp.wstrobe ||
        (act.wdata & mask) !== (exp.wdata & mask)) begin
      $display("ERR %s: expected addr %h wr %b strb %b data %h", name,
               exp.addr, exp.write, exp.wstrobe, exp.wdata & mask);
      $display("    actual addr %h wr %b strb %b data %h",
               act.addr, act.write, act.wstrobe, act.wdata & mask);
      check_errs++;
    end
  endtask

  // d is the store data, or the expected result of a load
  task automatic queue_req(input logic [31:0] a, input dc_op_e op, input dc_size_e sz,
                           input logic sext, input logic unc, input logic [31:0] d);
    lsu_req_t r;
    r = '0;
    r.vaddr    = a;
    r.op       = op;
    r.size     = sz;
    r.sign_ext = sext;
    r.uncached = unc;
    if (op == OP_READ) begin
      batch_exp.push_back(d);
    end else begin
      r.wdata = d;
    end
    batch_req.push_back(r);
  endtask

  // issue the queued requests back to back and check every load result in order
  task automatic run_batch(input string name);
    int idx;
    int got;
    int need;
    int cycles;
    idx = 0;
    got = 0;
    cycles = 0;
    need = batch_exp.size();
    while ((idx < batch_req.size() || got < need) && cycles < TIMEOUT) begin
      @(posedge clk);
      if (idx < batch_req.size()) begin
        req       <= batch_req[idx];
        req_valid <= 1'b1;
      end else begin
        req_valid <= 1'b0;
      end
      @(negedge clk);
      cycles++;
      if (resp_valid) begin
        if (got < need) begin
          check_word(name, batch_exp[got], resp);
        end else begin
          $display("%s: a response came with no load waiting for it", name);
          check_errs++;
        end
        got++;
      end
      if (req_valid && req_ready) begin
        idx++;
      end
    end
    @(posedge clk);
    req_valid <= 1'b0;
    if (idx < batch_req.size() || got < need) begin
      $display("%s: timed out, %0d of %0d responses seen", name, got, need);
      timeout_errs++;
    end
    batch_cycles = cycles;
    batch_req.delete();
    batch_exp.delete();
  endtask

  task automatic test_miss_then_hits();
    rd_cnt = 0;
    queue_req(32'h040, OP_READ, SZ_W, 1'b0, 1'b0, mem_word(32'h040));
    run_batch("miss_then_hits");
    check_count("miss_then_hits refill reads", 4, rd_cnt);
    rd_cnt = 0;
    for (int i = 1; i < 4; i++) begin
      queue_req(32'h040 + 4 * i, OP_READ, SZ_W, 1'b0, 1'b0, mem_word(32'h040 + 4 * i));
    end
    run_batch("miss_then_hits");
    check_count("miss_then_hits hit reads", 0, rd_cnt);
    // three issue cycles plus two of latency plus the drive cycle
    check_count("miss_then_hits hit cycles", 6, batch_cycles);
  endtask

  task automatic test_formatting();
    logic [31:0] w;
    logic [31:0] k;
    w = mem_word(32'h080);
    k = 32'h7f80_ff01;
    queue_req(32'h080, OP_READ, SZ_W, 1'b0, 1'b0, w);
    queue_req(32'h084, OP_WRITE, SZ_W, 1'b0, 1'b0, k);
    for (int off = 0; off < 4; off++) begin
      for (int s = 0; s < 2; s++) begin
        queue_req(32'h080 + off, OP_READ, SZ_B, 1'(s), 1'b0, fmt_load(w, 2'(off), SZ_B, 1'(s)));
        queue_req(32'h084 + off, OP_READ, SZ_B, 1'(s), 1'b0, fmt_load(k, 2'(off), SZ_B, 1'(s)));
        if (off % 2 == 0) begin
          queue_req(32'h080 + off, OP_READ, SZ_H, 1'(s), 1'b0,
                    fmt_load(w, 2'(off), SZ_H, 1'(s)));
          queue_req(32'h084 + off, OP_READ, SZ_H, 1'(s), 1'b0,
                    fmt_load(k, 2'(off), SZ_H, 1'(s)));
        end
      end
    end
    run_batch("sub_word_format");
  endtask

  task automatic store_then_load(input string name, input logic [31:0] a, input dc_size_e sz,
                                 input logic [31:0] d);
    logic [31:0] merged;
    merged = store_merge(mem_word(a), a[1:0], sz, d);
    rd_cnt = 0;
    wr_log.delete();
    queue_req(a, OP_WRITE, sz, 1'b0, 1'b0, d);
    queue_req({a[31:2], 2'b00}, OP_READ, SZ_W, 1'b0, 1'b0, merged);
    run_batch(name);
    check_count({name, " bus reads"}, 0, rd_cnt);
    check_count({name, " bus writes"}, 1, wr_log.size());
    if (wr_log.size() == 1) begin
      check_mem_req(name, store_req(a, sz, d), wr_log[0]);
    end
    check_word({name, " memory word"}, merged, mem_word(a));
  endtask

  task automatic test_write_through();
    queue_req(32'h0c0, OP_READ, SZ_W, 1'b0, 1'b0, mem_word(32'h0c0));
    run_batch("write_through");
    store_then_load("store_byte_hit", 32'h0c5, SZ_B, 32'h0000_00a5);
    store_then_load("store_half_hit", 32'h0ca, SZ_H, 32'h0000_beef);
    store_then_load("store_word_hit", 32'h0cc, SZ_W, 32'h1357_9bdf);
    // no write-allocate, the load after the store still refills
    rd_cnt = 0;
    queue_req(32'h1c8, OP_WRITE, SZ_W, 1'b0, 1'b0, 32'hc001_d00d);
    queue_req(32'h1c8, OP_READ, SZ_W, 1'b0, 1'b0, 32'hc001_d00d);
    run_batch("store_miss");
    check_count("store_miss refill reads", 4, rd_cnt);
  endtask

  // 0x100, 0x500 and 0x900 all map to set 16
  task automatic test_replacement();
    queue_req(32'h104, OP_READ, SZ_W, 1'b0, 1'b0, mem_word(32'h104));
    queue_req(32'h508, OP_READ, SZ_W, 1'b0, 1'b0, mem_word(32'h508));
    queue_req(32'h90c, OP_READ, SZ_W, 1'b0, 1'b0, mem_word(32'h90c));
    queue_req(32'h100, OP_READ, SZ_W, 1'b0, 1'b0, mem_word(32'h100));
    queue_req(32'h504, OP_READ, SZ_W, 1'b0, 1'b0, mem_word(32'h504));
    run_batch("replacement");
  endtask

  task automatic test_uncached_inv();
    logic [31:0] old_w;
    logic [31:0] new_w;
    old_w = mem_word(32'h208);
    new_w = old_w ^ 32'hf0f0_a55a;
    queue_req(32'h208, OP_READ, SZ_W, 1'b0, 1'b0, old_w);
    queue_req(32'h208, OP_WRITE, SZ_W, 1'b0, 1'b1, new_w);
    queue_req(32'h208, OP_READ, SZ_W, 1'b0, 1'b0, old_w);
    run_batch("uncached_store");
    check_word("uncached_store memory word", new_w, mem_word(32'h208));
    rd_cnt = 0;
    queue_req(32'h200, OP_INV, SZ_W, 1'b0, 1'b0, 32'h0);
    queue_req(32'h208, OP_READ, SZ_W, 1'b0, 1'b0, new_w);
    run_batch("invalidate");
    check_count("invalidate refill reads", 4, rd_cnt);
    rd_cnt = 0;
    queue_req(32'h20a, OP_READ, SZ_H, 1'b1, 1'b1, fmt_load(new_w, 2'd2, SZ_H, 1'b1));
    run_batch("uncached_load_half");
    check_count("uncached_load_half reads", 1, rd_cnt);
    rd_cnt = 0;
    queue_req(32'h30d, OP_READ, SZ_B, 1'b1, 1'b1, fmt_load(mem_word(32'h30c), 2'd1, SZ_B, 1'b1));
    run_batch("uncached_load_byte");
    check_count("uncached_load_byte reads", 1, rd_cnt);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    req          = '0;
    req_valid    = 1'b0;
    mem_stall    = 1'b0;
    lfsr_q       = 32'h931b;
    check_errs   = 0;
    timeout_errs = 0;
    rd_cnt       = 0;
    batch_cycles = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (!req_ready || resp_valid || mem_req_valid) begin
      $display("cache is not idle after reset");
      check_errs++;
    end
    test_miss_then_hits();
    test_formatting();
    test_write_through();
    test_replacement();
    test_uncached_inv();
    $display("errors: %0d failed checks, %0d timeouts", check_errs, timeout_errs);
    if (check_errs == 0 && timeout_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* dcache_top.f */
+incdir+design
design/dcache_pkg.sv
design/dcache_sdp_ram.sv
design/dcache_rport.sv
design/dcache_wport.sv
design/dcache_top.sv
tests/dcache_mem_model.sv
tests/dcache_tb.sv
